//--- bht.sv
// branch history table of 2-bit saturating counters, read by fetch pc and trained by resolve
`timescale 1ns/1ps

module bht import fe_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  resolve_if.sink         upd,
  input  logic [XLEN-1:0] pc_i,
  output logic            hit_o,
  output logic            taken_o
);

  logic [BHT_ENTRIES-1:0] vld_q;
  logic [1:0]             cnt_q [BHT_ENTRIES];
  logic [BHT_IDX_W-1:0]   rd_idx;
  logic [BHT_IDX_W-1:0]   up_idx;
  logic                   upd_en;
  logic [1:0]             cnt_old;
  logic [1:0]             cnt_new;

  assign rd_idx = pc_i[BHT_IDX_W+1:2];
  assign up_idx = upd.pc[BHT_IDX_W+1:2];
  assign upd_en = upd.valid & upd.is_branch;

  // lookup is purely combinational
  assign hit_o   = vld_q[rd_idx];
  assign taken_o = cnt_q[rd_idx][1];

  // --------------------
  // counter update
  // --------------------
  assign cnt_old = cnt_q[up_idx];

  always_comb begin
    cnt_new = cnt_old;
    if (!vld_q[up_idx]) begin
      // first sighting starts weakly in the resolved direction
      cnt_new = upd.taken ? 2'd2 : 2'd1;
    end else if (upd.taken && cnt_old != 2'd3) begin
      cnt_new = cnt_old + 2'd1;
    end else if (!upd.taken && cnt_old != 2'd0) begin
      cnt_new = cnt_old - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else if (upd_en) begin
      vld_q[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (upd_en) begin
      cnt_q[up_idx] <= cnt_new;
    end
  end

endmodule

//--- fe_if.sv
// branch resolution and predecode-to-queue interfaces used between frontend blocks
`timescale 1ns/1ps

// resolved control flow coming back from execute
interface resolve_if import fe_pkg::*; ();
  logic            valid;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] target;
  logic            taken;
  logic            is_branch;
  logic            mispredict;

  // counter training side
  modport sink (
    input valid,
    input pc,
    input taken,
    input is_branch
  );

  // fetch redirect side
  modport redirect (
    input valid,
    input target,
    input mispredict
  );
endinterface

// predicted entry handed from predecode into the fetch queue
interface pred_if import fe_pkg::*; ();
  logic         valid;
  fetch_entry_t entry;
  // queue not full
  logic         accept;

  modport predecode (output valid, output entry, input accept);
  modport queue (input valid, input entry, output accept);
  // pc generation watches the same transfer
  modport pcgen (input valid, input entry, input accept);
endinterface

//--- fe_pkg.sv
// shared widths, depths, control-flow kinds and entry types, imported by every frontend block
package fe_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int XLEN        = 32;
  localparam int BHT_ENTRIES = 16;
  // index comes from pc bits 5..2
  localparam int BHT_IDX_W   = 4;
  localparam int RAS_DEPTH   = 4;
  localparam int FQ_DEPTH    = 4;
  localparam int FQ_PTR_W    = $clog2(FQ_DEPTH);
  localparam int FQ_CNT_W    = $clog2(FQ_DEPTH + 1);

  // rv32i opcodes of interest to the predecoder
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef enum logic [2:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JUMP,
    CF_JALR,
    CF_RETURN
  } cf_e;

  // --------------------
  // instruction formats
  // --------------------
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // one fetched word, seen through each format the predecoder needs
  typedef union packed {
    b_type_t b;
    j_type_t j;
    i_type_t i;
  } instr_u;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    cf_e             cf;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;
  } fetch_entry_t;

endpackage

//--- fetch_frontend.sv
// rv32i fetch frontend top, maps the plain core ports onto the internal blocks
`timescale 1ns/1ps

module fetch_frontend import fe_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            ex_valid_i,
  input  logic [XLEN-1:0] trap_vector_base_i,
  input  logic            resolve_valid_i,
  input  logic            resolve_is_branch_i,
  input  logic            resolve_taken_i,
  input  logic            resolve_mispredict_i,
  input  logic [XLEN-1:0] resolve_pc_i,
  input  logic [XLEN-1:0] resolve_target_i,
  output logic            imem_req_o,
  output logic [XLEN-1:0] imem_addr_o,
  input  logic            imem_valid_i,
  input  logic [XLEN-1:0] imem_rdata_i,
  output logic            fetch_valid_o,
  input  logic            fetch_ready_i,
  output logic [XLEN-1:0] fetch_pc_o,
  output logic [XLEN-1:0] fetch_instr_o,
  output logic [XLEN-1:0] fetch_pred_target_o,
  output cf_e             fetch_cf_o,
  output logic            fetch_pred_taken_o
);

  resolve_if res_bus ();
  pred_if    pred_bus ();

  logic            kill;
  logic            rsp_live;
  logic [XLEN-1:0] rsp_pc;
  logic [XLEN-1:0] bht_pc;
  logic            bht_hit, bht_taken;
  logic            ras_push, ras_pop;
  logic [XLEN-1:0] ras_push_addr;
  logic            ras_top_valid;
  logic [XLEN-1:0] ras_top_addr;
  fetch_entry_t    fq_entry;

  assign res_bus.valid      = resolve_valid_i;
  assign res_bus.pc         = resolve_pc_i;
  assign res_bus.target     = resolve_target_i;
  assign res_bus.taken      = resolve_taken_i;
  assign res_bus.is_branch  = resolve_is_branch_i;
  assign res_bus.mispredict = resolve_mispredict_i;

  fetch_pc_gen u_pc_gen (
    .clk_i, .rst_ni, .boot_addr_i, .ex_valid_i, .trap_vector_base_i,
    .res (res_bus), .pred (pred_bus), .imem_valid_i, .imem_req_o, .imem_addr_o,
    .rsp_live_o (rsp_live), .rsp_pc_o (rsp_pc), .kill_o (kill)
  );

  fetch_predecode u_predecode (
    .clk_i, .rst_ni, .kill_i (kill), .imem_valid_i, .imem_rdata_i,
    .rsp_live_i (rsp_live), .rsp_pc_i (rsp_pc), .pred (pred_bus),
    .bht_pc_o (bht_pc), .bht_hit_i (bht_hit), .bht_taken_i (bht_taken),
    .ras_push_o (ras_push), .ras_pop_o (ras_pop), .ras_push_addr_o (ras_push_addr),
    .ras_top_valid_i (ras_top_valid), .ras_top_addr_i (ras_top_addr)
  );

  bht u_bht (
    .clk_i, .rst_ni, .upd (res_bus), .pc_i (bht_pc), .hit_o (bht_hit), .taken_o (bht_taken)
  );

  ras u_ras (
    .clk_i, .rst_ni, .push_i (ras_push), .pop_i (ras_pop), .push_addr_i (ras_push_addr),
    .top_valid_o (ras_top_valid), .top_addr_o (ras_top_addr)
  );

  fetch_queue u_queue (
    .clk_i, .rst_ni, .kill_i (kill), .pred (pred_bus),
    .fetch_valid_o, .fetch_ready_i, .fetch_entry_o (fq_entry)
  );

  // unpack the head entry for decode
  assign fetch_pc_o          = fq_entry.pc;
  assign fetch_instr_o       = fq_entry.instr;
  assign fetch_cf_o          = fq_entry.cf;
  assign fetch_pred_taken_o  = fq_entry.pred_taken;
  assign fetch_pred_target_o = fq_entry.pred_target;

endmodule

//--- fetch_pc_gen.sv
// selects the next fetch address and issues single outstanding instruction memory requests
`timescale 1ns/1ps

module fetch_pc_gen import fe_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            ex_valid_i,
  input  logic [XLEN-1:0] trap_vector_base_i,
  resolve_if.redirect     res,
  pred_if.pcgen           pred,
  input  logic            imem_valid_i,
  output logic            imem_req_o,
  output logic [XLEN-1:0] imem_addr_o,
  output logic            rsp_live_o,
  output logic [XLEN-1:0] rsp_pc_o,
  output logic            kill_o
);

  logic [XLEN-1:0] pc_q, pc_d;
  logic            booted_q;
  logic            issue_q, issue_d;
  logic            out_q, out_d;
  logic            stale_q, stale_d;
  logic            mispredict;
  logic            xfer;
  logic            req;

  assign mispredict = res.valid & res.mispredict;
  assign kill_o     = ex_valid_i | mispredict;
  assign xfer       = pred.valid & pred.accept;

  // wait for any outstanding (possibly stale) response before asking again
  assign req         = issue_q & ~out_q;
  assign imem_req_o  = req;
  assign imem_addr_o = pc_q;

  // pc_q only moves on kill or transfer, so it still names the live request
  assign rsp_live_o = imem_valid_i & out_q & ~stale_q;
  assign rsp_pc_o   = pc_q;

  // --------------------
  // next pc
  // --------------------
  always_comb begin
    pc_d = pc_q;
    if (!booted_q) begin
      pc_d = boot_addr_i;
    end else if (ex_valid_i) begin
      pc_d = trap_vector_base_i;
    end else if (mispredict) begin
      pc_d = res.target;
    end else if (xfer && pred.entry.pred_taken) begin
      pc_d = pred.entry.pred_target;
    end else if (xfer) begin
      pc_d = pred.entry.pc + 32'd4;
    end
  end

  // --------------------
  // request tracking
  // --------------------
  always_comb begin
    out_d   = out_q;
    stale_d = stale_q;
    issue_d = issue_q;
    if (req) begin
      out_d = 1'b1;
    end else if (imem_valid_i) begin
      out_d = 1'b0;
    end
    if (imem_valid_i) begin
      stale_d = 1'b0;
    end
    // a request in flight when the kill lands is dropped on arrival
    if (kill_o) begin
      stale_d = req | (out_q & ~imem_valid_i);
    end
    if (req) begin
      issue_d = 1'b0;
    end
    if (!booted_q || kill_o || xfer) begin
      issue_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q     <= '0;
      booted_q <= 1'b0;
      issue_q  <= 1'b0;
      out_q    <= 1'b0;
      stale_q  <= 1'b0;
    end else begin
      pc_q     <= pc_d;
      booted_q <= 1'b1;
      issue_q  <= issue_d;
      out_q    <= out_d;
      stale_q  <= stale_d;
    end
  end

  // memory must only answer requests this block actually issued
  a_rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_valid_i |-> out_q)
    else $error("imem response without outstanding request");

endmodule

//--- fetch_predecode.sv
// holds the fetched word, classifies its control flow and forms the branch prediction
`timescale 1ns/1ps

module fetch_predecode import fe_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            kill_i,
  input  logic            imem_valid_i,
  input  logic [XLEN-1:0] imem_rdata_i,
  input  logic            rsp_live_i,
  input  logic [XLEN-1:0] rsp_pc_i,
  pred_if.predecode       pred,
  output logic [XLEN-1:0] bht_pc_o,
  input  logic            bht_hit_i,
  input  logic            bht_taken_i,
  output logic            ras_push_o,
  output logic            ras_pop_o,
  output logic [XLEN-1:0] ras_push_addr_o,
  input  logic            ras_top_valid_i,
  input  logic [XLEN-1:0] ras_top_addr_i
);

  logic            valid_q;
  logic [XLEN-1:0] pc_q;
  instr_u          instr_q;
  logic            take_rsp;
  logic            xfer;
  logic            is_branch, is_jal, is_jalr, is_call, is_return;
  logic [XLEN-1:0] b_imm, j_imm, seq_pc;
  logic            taken;
  cf_e             cf;
  logic [XLEN-1:0] target;
  fetch_entry_t    entry;

  assign take_rsp = imem_valid_i & rsp_live_i;

  // --------------------
  // stage register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (kill_i) begin
      valid_q <= 1'b0;
    end else if (take_rsp) begin
      valid_q <= 1'b1;
    end else if (xfer) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_rsp) begin
      pc_q    <= rsp_pc_i;
      instr_q <= imem_rdata_i;
    end
  end

  // --------------------
  // classification
  // --------------------
  assign is_branch = instr_q.b.opcode == OPC_BRANCH;
  assign is_jal    = instr_q.j.opcode == OPC_JAL;
  assign is_jalr   = (instr_q.i.opcode == OPC_JALR) && (instr_q.i.funct3 == 3'b000);
  // link register x1 or x5
  assign is_call   = is_jal && (instr_q.j.rd == 5'd1 || instr_q.j.rd == 5'd5);
  assign is_return = is_jalr && (instr_q.i.rd == 5'd0) &&
                     (instr_q.i.rs1 == 5'd1 || instr_q.i.rs1 == 5'd5);

  assign b_imm = {{19{instr_q.b.imm12}}, instr_q.b.imm12, instr_q.b.imm11,
                  instr_q.b.imm10_5, instr_q.b.imm4_1, 1'b0};
  assign j_imm = {{11{instr_q.j.imm20}}, instr_q.j.imm20, instr_q.j.imm19_12,
                  instr_q.j.imm11, instr_q.j.imm10_1, 1'b0};
  assign seq_pc = pc_q + 32'd4;

  // target is the predicted next fetch address, pc+4 when not taken
  always_comb begin
    cf     = CF_NONE;
    taken  = 1'b0;
    target = seq_pc;
    if (is_branch) begin
      cf = CF_BRANCH;
      // no history yet, backward taken and forward not taken
      taken = bht_hit_i ? bht_taken_i : b_imm[XLEN-1];
      if (taken) begin
        target = pc_q + b_imm;
      end
    end else if (is_jal) begin
      cf     = CF_JUMP;
      taken  = 1'b1;
      target = pc_q + j_imm;
    end else if (is_return) begin
      cf    = CF_RETURN;
      taken = ras_top_valid_i;
      if (ras_top_valid_i) begin
        target = ras_top_addr_i;
      end
    end else if (is_jalr) begin
      cf = CF_JALR;
    end
  end

  always_comb begin
    entry.pc          = pc_q;
    entry.instr       = instr_q;
    entry.cf          = cf;
    entry.pred_taken  = taken;
    entry.pred_target = target;
  end

  assign pred.valid = valid_q;
  assign pred.entry = entry;
  assign xfer       = valid_q & pred.accept;

  // stack only moves for entries that really enter the queue
  assign bht_pc_o        = pc_q;
  assign ras_push_o      = xfer & ~kill_i & is_call;
  assign ras_pop_o       = xfer & ~kill_i & is_return;
  assign ras_push_addr_o = seq_pc;

endmodule

//--- fetch_queue.sv
// circular FIFO of predicted fetch entries feeding decode with valid/ready
`timescale 1ns/1ps

module fetch_queue import fe_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         kill_i,
  pred_if.queue        pred,
  output logic         fetch_valid_o,
  input  logic         fetch_ready_i,
  output fetch_entry_t fetch_entry_o
);

  fetch_entry_t        mem_q [FQ_DEPTH];
  logic [FQ_PTR_W-1:0] wr_ptr_q;
  logic [FQ_PTR_W-1:0] rd_ptr_q;
  logic [FQ_CNT_W-1:0] cnt_q;
  logic                push;
  logic                pop;

  assign pred.accept   = cnt_q != FQ_CNT_W'(FQ_DEPTH);
  assign fetch_valid_o = cnt_q != '0;
  assign fetch_entry_o = mem_q[rd_ptr_q];

  assign push = pred.valid & pred.accept;
  assign pop  = fetch_valid_o & fetch_ready_i;

  // --------------------
  // pointers and count
  // --------------------
  // depth is a power of two so the pointers simply wrap
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (kill_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage, a write during kill is harmless once the pointers clear
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= pred.entry;
    end
  end

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= FQ_CNT_W'(FQ_DEPTH))
    else $error("fetch queue count above depth");

endmodule

//--- ras.sv
// return address stack, pushed by calls and popped by returns as they leave predecode
`timescale 1ns/1ps

module ras import fe_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            push_i,
  input  logic            pop_i,
  input  logic [XLEN-1:0] push_addr_i,
  output logic            top_valid_o,
  output logic [XLEN-1:0] top_addr_o
);

  // slot 0 is the top of stack
  logic [RAS_DEPTH-1:0] vld_q;
  logic [XLEN-1:0]      addr_q [RAS_DEPTH];

  assign top_valid_o = vld_q[0];
  assign top_addr_o  = addr_q[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else if (push_i) begin
      // oldest entry falls off the bottom
      vld_q <= {vld_q[RAS_DEPTH-2:0], 1'b1};
    end else if (pop_i) begin
      vld_q <= {1'b0, vld_q[RAS_DEPTH-1:1]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_q[0] <= push_addr_i;
      for (int i = 1; i < RAS_DEPTH; i++) begin
        addr_q[i] <= addr_q[i-1];
      end
    end else if (pop_i) begin
      for (int i = 0; i < RAS_DEPTH - 1; i++) begin
        addr_q[i] <= addr_q[i+1];
      end
    end
  end

  // a single instruction is never both a call and a return
  a_no_push_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && pop_i))
    else $error("ras push and pop in the same cycle");

endmodule

//--- tb.f
fe_pkg.sv
fe_if.sv
bht.sv
ras.sv
fetch_queue.sv
fetch_pc_gen.sv
fetch_predecode.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- tb_fetch_frontend.sv
// testbench for the fetch frontend, runs small programs and checks decode entries against a model
`timescale 1ns/1ps

module tb_fetch_frontend import fe_pkg::*; ();

  localparam int N_STRAIGHT = 8;
  localparam int N_CALL     = 8;
  // bht and redirect tests collect this many per phase
  localparam int N_BHT      = 6;
  localparam int N_STALL    = 24;
  localparam int N_REDIR    = 4;
  localparam int TOTAL_ENTRIES = N_STRAIGHT + N_CALL + 2 * N_BHT + N_STALL + 4 * N_REDIR;
  // three cycles per instruction plus room for resets, redirects and stalls
  localparam int WATCHDOG_CYCLES = TOTAL_ENTRIES * 3 + 1000;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic [31:0] boot_addr_i;
  logic        ex_valid_i;
  logic [31:0] trap_vector_base_i;
  logic        resolve_valid_i, resolve_is_branch_i, resolve_taken_i, resolve_mispredict_i;
  logic [31:0] resolve_pc_i, resolve_target_i;
  logic        imem_req_o;
  logic [31:0] imem_addr_o;
  logic        imem_valid_i = 1'b0;
  logic [31:0] imem_rdata_i = '0;
  logic        fetch_valid_o;
  logic        fetch_ready_i;
  logic [31:0] fetch_pc_o, fetch_instr_o, fetch_pred_target_o;
  cf_e         fetch_cf_o;
  logic        fetch_pred_taken_o;

  // program memory, stimulus and model state
  logic [31:0] prog [256];
  integer      seed = 32'hd20bb20d;
  logic        mem_busy;
  int          mem_wait;
  logic [31:0] mem_addr;
  logic [31:0] m_pc;
  logic [31:0] ras_q [$];
  logic        m_vld [BHT_ENTRIES];
  logic [1:0]  m_cnt [BHT_ENTRIES];
  logic [31:0] exp_pc, exp_instr, exp_target;
  cf_e         exp_cf;
  logic        exp_taken;
  logic        first_req_pend;
  logic        xfer, kill_in;
  int          n_xfer = 0;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          err_at_start;

  fetch_frontend dut_i (.*);

  always #50 clk_i = ~clk_i;

  assign xfer    = fetch_valid_o & fetch_ready_i;
  assign kill_in = ex_valid_i | (resolve_valid_i & resolve_mispredict_i);

  // --------------------
  // helpers
  // --------------------
  // addi x10, x0, fold of the full address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[11:0] ^ addr[23:12] ^ {4'd0, addr[31:24]}, 5'd0, 3'b000, 5'd10, 7'b0010011};
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (addr < 32'h400) begin
      return prog[addr[9:2]];
    end
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] enc_branch(input logic [31:0] off, input logic [2:0] f3);
    return {off[12], off[10:5], 5'd0, 5'd0, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [31:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'd0, rs1, 3'b000, rd, OPC_JALR};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    err_cnt++;
    $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("error: %s at %0t", msg, $time);
  endtask

  // --------------------
  // memory model
  // --------------------
  always @(negedge clk_i) begin
    imem_valid_i = 1'b0;
    if (!rst_ni) begin
      mem_busy = 1'b0;
    end else begin
      if (mem_busy) begin
        mem_wait = mem_wait - 1;
        if (mem_wait == 0) begin
          imem_valid_i = 1'b1;
          imem_rdata_i = mem_word(mem_addr);
          mem_busy     = 1'b0;
        end
      end
      if (imem_req_o) begin
        mem_busy = 1'b1;
        mem_addr = imem_addr_o;
        mem_wait = ($random(seed) & 32'h7fff_ffff) % 3 + 1;
      end
    end
  end

  // --------------------
  // reference model
  // --------------------
  // expected decode entry at m_pc from the prediction rules
  task automatic predict_next();
    logic [31:0] w, bimm, jimm;
    logic [3:0]  idx;
    w    = mem_word(m_pc);
    bimm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    idx  = m_pc[5:2];
    exp_pc     = m_pc;
    exp_instr  = w;
    exp_cf     = CF_NONE;
    exp_taken  = 1'b0;
    exp_target = m_pc + 32'd4;
    if (w[6:0] == OPC_BRANCH) begin
      exp_cf    = CF_BRANCH;
      exp_taken = m_vld[idx] ? (m_cnt[idx] >= 2'd2) : bimm[31];
      if (exp_taken) begin
        exp_target = m_pc + bimm;
      end
    end else if (w[6:0] == OPC_JAL) begin
      exp_cf     = CF_JUMP;
      exp_taken  = 1'b1;
      exp_target = m_pc + jimm;
    end else if (w[6:0] == OPC_JALR && w[14:12] == 3'b000) begin
      exp_cf = CF_JALR;
      if (w[11:7] == 5'd0 && (w[19:15] == 5'd1 || w[19:15] == 5'd5)) begin
        exp_cf = CF_RETURN;
        if (ras_q.size() > 0) begin
          exp_taken  = 1'b1;
          exp_target = ras_q[0];
        end
      end
    end
  endtask

  task automatic train_bht(input logic [31:0] pc, input logic taken);
    logic [3:0] idx;
    idx = pc[5:2];
    if (!m_vld[idx]) begin
      m_cnt[idx] = taken ? 2'd2 : 2'd1;
    end else if (taken && m_cnt[idx] != 2'd3) begin
      m_cnt[idx] = m_cnt[idx] + 2'd1;
    end else if (!taken && m_cnt[idx] != 2'd0) begin
      m_cnt[idx] = m_cnt[idx] - 2'd1;
    end
    m_vld[idx] = 1'b1;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      foreach (m_vld[i]) begin
        m_vld[i] = 1'b0;
      end
      ras_q.delete();
      m_pc           = boot_addr_i;
      first_req_pend = 1'b1;
    end else begin
      if (imem_req_o) begin
        first_req_pend = 1'b0;
      end
      if (resolve_valid_i && resolve_is_branch_i) begin
        train_bht(resolve_pc_i, resolve_taken_i);
      end
      // exception outranks mispredict
      if (ex_valid_i) begin
        m_pc = trap_vector_base_i;
      end else if (resolve_valid_i && resolve_mispredict_i) begin
        m_pc = resolve_target_i;
      end else if (xfer) begin
        if (exp_cf == CF_JUMP && (exp_instr[11:7] == 5'd1 || exp_instr[11:7] == 5'd5)) begin
          ras_q.push_front(exp_pc + 32'd4);
          if (ras_q.size() > RAS_DEPTH) begin
            void'(ras_q.pop_back());
          end
        end
        if (exp_cf == CF_RETURN && ras_q.size() > 0) begin
          void'(ras_q.pop_front());
        end
        m_pc   = exp_target;
        n_xfer = n_xfer + 1;
      end
    end
    predict_next();
  end

  // --------------------
  // checks
  // --------------------
  a_no_req_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !imem_req_o)
    else report_error("memory request issued during reset");
  a_boot_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (first_req_pend && imem_req_o) |-> imem_addr_o == boot_addr_i)
    else report_mismatch("imem_addr_o", $sampled(imem_addr_o), $sampled(boot_addr_i));
  a_pc: assert property (@(posedge clk_i) disable iff (!rst_ni) xfer |-> fetch_pc_o == exp_pc)
    else report_mismatch("fetch_pc_o", $sampled(fetch_pc_o), $sampled(exp_pc));
  a_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    xfer |-> fetch_instr_o == exp_instr)
    else report_mismatch("fetch_instr_o", $sampled(fetch_instr_o), $sampled(exp_instr));
  a_cf: assert property (@(posedge clk_i) disable iff (!rst_ni) xfer |-> fetch_cf_o == exp_cf)
    else report_mismatch("fetch_cf_o", 32'($sampled(fetch_cf_o)), 32'($sampled(exp_cf)));
  a_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    xfer |-> fetch_pred_taken_o == exp_taken)
    else report_mismatch("fetch_pred_taken_o", 32'($sampled(fetch_pred_taken_o)),
                         32'($sampled(exp_taken)));
  a_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    xfer |-> fetch_pred_target_o == exp_target)
    else report_mismatch("fetch_pred_target_o", $sampled(fetch_pred_target_o),
                         $sampled(exp_target));
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_valid_o && !fetch_ready_i && !kill_in) |=>
      (fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_instr_o)))
    else report_error("decode entry dropped or changed while stalled");

  // --------------------
  // stimulus
  // --------------------
  task automatic prepare(input logic [31:0] boot);
    rst_ni      = 1'b0;
    boot_addr_i = boot;
    for (int i = 0; i < 256; i++) begin
      prog[i] = fill_word(32'(i) << 2);
    end
    err_at_start = err_cnt;
  endtask

  task automatic release_reset();
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // called at a falling edge, returns at one with ready low
  task automatic collect(input int n, input bit random_ready);
    int start;
    start = n_xfer;
    while (n_xfer - start < n) begin
      fetch_ready_i = random_ready ? (($random(seed) & 1) != 0) : 1'b1;
      @(negedge clk_i);
    end
    fetch_ready_i = 1'b0;
  endtask

  task automatic redirect(input bit ex, input logic [31:0] trap, input bit misp,
                          input logic [31:0] tgt, input bit is_br, input logic [31:0] br_pc);
    ex_valid_i           = ex;
    trap_vector_base_i   = trap;
    resolve_valid_i      = misp | is_br;
    resolve_mispredict_i = misp;
    resolve_target_i     = tgt;
    resolve_is_branch_i  = is_br;
    resolve_taken_i      = is_br;
    resolve_pc_i         = br_pc;
    @(negedge clk_i);
    ex_valid_i           = 1'b0;
    resolve_valid_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_is_branch_i  = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_cnt == err_at_start) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", tests_run, name, err_cnt - err_at_start);
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    boot_addr_i = '0;
    ex_valid_i = 1'b0;
    trap_vector_base_i = '0;
    resolve_valid_i = 1'b0;
    resolve_is_branch_i = 1'b0;
    resolve_taken_i = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_pc_i = '0;
    resolve_target_i = '0;
    fetch_ready_i = 1'b0;

    prepare(32'h80);
    release_reset();
    collect(N_STRAIGHT, 1'b0);
    finish_test("straight-line fetch");

    // call to 0x240, return to 0x204, then a return with an empty stack
    prepare(32'h200);
    prog[32'h200 >> 2] = enc_jal(32'h40, 5'd1);
    prog[32'h244 >> 2] = enc_jalr(5'd0, 5'd1);
    prog[32'h204 >> 2] = enc_jalr(5'd0, 5'd1);
    release_reset();
    collect(N_CALL, 1'b0);
    finish_test("call and return");

    // forward branch at 0x100, backward loop branch at 0x108
    prepare(32'h100);
    prog[32'h100 >> 2] = enc_branch(32'd16, 3'b000);
    prog[32'h108 >> 2] = enc_branch(-32'sd8, 3'b001);
    prog[32'h110 >> 2] = enc_jal(-32'sd16, 5'd0);
    release_reset();
    collect(N_BHT, 1'b0);
    redirect(1'b0, '0, 1'b1, 32'h110, 1'b1, 32'h100);
    collect(N_BHT, 1'b0);
    finish_test("static and trained branch prediction");

    // loop with a call through x1 and a return through x5
    prepare(32'h300);
    prog[32'h304 >> 2] = enc_jal(32'h20, 5'd1);
    prog[32'h324 >> 2] = enc_jalr(5'd0, 5'd5);
    prog[32'h30c >> 2] = enc_branch(-32'sd12, 3'b101);
    release_reset();
    collect(N_STALL, 1'b1);
    finish_test("random decode back-pressure");

    prepare(32'h80);
    release_reset();
    collect(N_REDIR, 1'b0);
    redirect(1'b0, '0, 1'b1, 32'h180, 1'b0, '0);
    collect(N_REDIR, 1'b0);
    redirect(1'b1, 32'h3c0, 1'b0, '0, 1'b0, '0);
    collect(N_REDIR, 1'b0);
    redirect(1'b1, 32'h1c0, 1'b1, 32'h2c0, 1'b0, '0);
    collect(N_REDIR, 1'b0);
    finish_test("mispredict and exception redirect");

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: decode stopped receiving entries after %0d transfers", n_xfer);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
